// ==== hdl/ddcPkg.sv ====
package ddcPkg;

    localparam logic [11:0] ddcCenterFreqAddr = 12'h000;
    localparam logic [11:0] ddcControlAddr    = 12'h004;

    // One register data word, seen as a tuning word or as control bits
    typedef union packed {
        logic [31:0] freq;
        struct packed {
            logic [29:0] reserved;
            logic        bypassHb;
            logic        bypassCic;
        } ctrl;
    } ddcRegWord;

    // First quadrant of the sine, 16384 * sin(k * 90 / 16 degrees)
    localparam logic signed [15:0] ncoQuarterTable [17] = '{
        16'sd0,     16'sd1606,  16'sd3196,  16'sd4756,
        16'sd6270,  16'sd7723,  16'sd9102,  16'sd10394,
        16'sd11585, 16'sd12665, 16'sd13623, 16'sd14449,
        16'sd15137, 16'sd15679, 16'sd16069, 16'sd16305,
        16'sd16384
    };

    localparam int ncoAmpShift = 14; // Table amplitude is 2**14

    // Halfband taps sum to 32
    localparam logic signed [5:0] hbCoef [7] = '{
        -6'sd1, 6'sd0, 6'sd9, 6'sd16, 6'sd9, 6'sd0, -6'sd1
    };

    localparam int hbShift = 5;

endpackage

// ==== hdl/ddcRegs.sv ====
module ddcRegs import ddcPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [11:0] addr,
    input  logic [31:0] wrData,
    input  logic [3:0]  byteEn,
    input  logic        wr,
    output logic [31:0] rdData,
    output logic [31:0] centerFreq,
    output logic        bypassCic,
    output logic        bypassHb
);

    ddcRegWord wrWord;
    ddcRegWord rdWord;

    assign wrWord = wrData;

    always_ff @(posedge clk) begin
        if (rst) begin
            centerFreq <= '0;
            bypassCic  <= 1'b0;
            bypassHb   <= 1'b0;
        end else if (wr) begin
            if (addr == ddcCenterFreqAddr) begin
                for (int b = 0; b < 4; b++) begin
                    if (byteEn[b]) begin
                        centerFreq[8*b +: 8] <= wrWord.freq[8*b +: 8];
                    end
                end
            end else if (addr == ddcControlAddr && byteEn[0]) begin
                bypassCic <= wrWord.ctrl.bypassCic; // Only byte 0 is mapped
                bypassHb  <= wrWord.ctrl.bypassHb;
            end
        end
    end

    always_comb begin
        rdWord = '0;
        case (addr)
            ddcCenterFreqAddr: rdWord.freq = centerFreq;
            ddcControlAddr: begin
                rdWord.ctrl.bypassHb  = bypassHb;
                rdWord.ctrl.bypassCic = bypassCic;
            end
            default: ;
        endcase
    end

    assign rdData = rdWord;

endmodule

// ==== hdl/ddcNcoMixer.sv ====
module ddcNcoMixer import ddcPkg::*; #(
    parameter int dataWidth = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [31:0]                 centerFreq,
    input  logic                        inValid,
    output logic                        inReady,
    input  logic signed [dataWidth-1:0] inData,
    output logic                        mixValid,
    input  logic                        mixReady,
    output logic signed [dataWidth-1:0] mixI,
    output logic signed [dataWidth-1:0] mixQ
);

    localparam int prodWidth = dataWidth + 16;

    logic [31:0]                 phase;
    logic [4:0]                  fineIdx;
    logic [4:0]                  mirIdx;
    logic signed [15:0]          sinMag;
    logic signed [15:0]          cosMag;
    logic signed [15:0]          sinVal;
    logic signed [15:0]          cosVal;
    logic signed [prodWidth-1:0] prodI;
    logic signed [prodWidth-1:0] prodQ;
    logic                        accept;

    assign inReady = !mixValid || mixReady;
    assign accept  = inValid && inReady;

    // Phase bits 31:30 pick the quadrant, 29:26 the table step
    assign fineIdx = {1'b0, phase[29:26]};
    assign mirIdx  = 5'd16 - fineIdx;

    // Odd quadrants run the table backwards, cosine is the mirrored sine
    assign sinMag = phase[30] ? ncoQuarterTable[mirIdx] : ncoQuarterTable[fineIdx];
    assign cosMag = phase[30] ? ncoQuarterTable[fineIdx] : ncoQuarterTable[mirIdx];
    assign sinVal = phase[31] ? -sinMag : sinMag; // Negative in quadrants 2 and 3
    assign cosVal = (phase[31] ^ phase[30]) ? -cosMag : cosMag;

    assign prodI = prodWidth'(inData) * prodWidth'(cosVal);
    assign prodQ = -(prodWidth'(inData) * prodWidth'(sinVal));

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= '0;
        end else if (accept) begin
            phase <= phase + centerFreq;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mixValid <= 1'b0;
        end else if (accept) begin
            mixValid <= 1'b1;
        end else if (mixReady) begin
            mixValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mixI <= dataWidth'(prodI >>> ncoAmpShift);
            mixQ <= dataWidth'(prodQ >>> ncoAmpShift);
        end
    end

endmodule

// ==== hdl/ddcCic.sv ====
module ddcCic #(
    parameter int dataWidth = 16,
    parameter int cicRate   = 4,
    parameter int cicStages = 3
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        bypass,
    input  logic                        mixValid,
    output logic                        mixReady,
    input  logic signed [dataWidth-1:0] mixI,
    input  logic signed [dataWidth-1:0] mixQ,
    output logic                        cicValid,
    input  logic                        cicReady,
    output logic signed [dataWidth-1:0] cicI,
    output logic signed [dataWidth-1:0] cicQ
);

    localparam int rateBits  = $clog2(cicRate);
    localparam int gainShift = cicStages * rateBits; // DC gain is cicRate**cicStages
    localparam int accWidth  = dataWidth + gainShift;

    logic signed [accWidth-1:0] integI [cicStages];
    logic signed [accWidth-1:0] integQ [cicStages];
    logic signed [accWidth-1:0] integNextI [cicStages];
    logic signed [accWidth-1:0] integNextQ [cicStages];
    logic signed [accWidth-1:0] combDlyI [cicStages];
    logic signed [accWidth-1:0] combDlyQ [cicStages];
    logic signed [accWidth-1:0] combOutI [cicStages];
    logic signed [accWidth-1:0] combOutQ [cicStages];
    logic [rateBits-1:0]        decCount;
    logic                       accept;
    logic                       groupDone;

    assign mixReady  = !cicValid || cicReady;
    assign accept    = mixValid && mixReady;
    assign groupDone = decCount == rateBits'(cicRate - 1);

    always_comb begin
        integNextI[0] = integI[0] + accWidth'(mixI);
        integNextQ[0] = integQ[0] + accWidth'(mixQ);
        for (int s = 1; s < cicStages; s++) begin
            integNextI[s] = integI[s] + integNextI[s-1];
            integNextQ[s] = integQ[s] + integNextQ[s-1];
        end
        combOutI[0] = integNextI[cicStages-1] - combDlyI[0]; // Combs see the decimated stream
        combOutQ[0] = integNextQ[cicStages-1] - combDlyQ[0];
        for (int s = 1; s < cicStages; s++) begin
            combOutI[s] = combOutI[s-1] - combDlyI[s];
            combOutQ[s] = combOutQ[s-1] - combDlyQ[s];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || bypass) begin
            decCount <= '0;
            for (int s = 0; s < cicStages; s++) begin
                integI[s]   <= '0;
                integQ[s]   <= '0;
                combDlyI[s] <= '0;
                combDlyQ[s] <= '0;
            end
        end else if (accept) begin
            decCount <= decCount + 1'b1; // Wraps at cicRate
            integI   <= integNextI;
            integQ   <= integNextQ;
            if (groupDone) begin
                combDlyI[0] <= integNextI[cicStages-1];
                combDlyQ[0] <= integNextQ[cicStages-1];
                for (int s = 1; s < cicStages; s++) begin
                    combDlyI[s] <= combOutI[s-1];
                    combDlyQ[s] <= combOutQ[s-1];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cicValid <= 1'b0;
        end else if (accept && (bypass || groupDone)) begin
            cicValid <= 1'b1;
        end else if (cicReady) begin
            cicValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && bypass) begin
            cicI <= mixI;
            cicQ <= mixQ;
        end else if (accept && groupDone) begin
            cicI <= dataWidth'(combOutI[cicStages-1] >>> gainShift);
            cicQ <= dataWidth'(combOutQ[cicStages-1] >>> gainShift);
        end
    end

endmodule

// ==== hdl/ddcHalfband.sv ====
module ddcHalfband import ddcPkg::*; #(
    parameter int dataWidth = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        bypass,
    input  logic                        cicValid,
    output logic                        cicReady,
    input  logic signed [dataWidth-1:0] cicI,
    input  logic signed [dataWidth-1:0] cicQ,
    output logic                        outValid,
    input  logic                        outReady,
    output logic signed [dataWidth-1:0] outI,
    output logic signed [dataWidth-1:0] outQ
);

    localparam int hbTaps   = 7;
    localparam int sumWidth = dataWidth + 7;

    logic signed [dataWidth-1:0] dlyI [hbTaps-1];
    logic signed [dataWidth-1:0] dlyQ [hbTaps-1];
    logic signed [dataWidth-1:0] winI [hbTaps];
    logic signed [dataWidth-1:0] winQ [hbTaps];
    logic signed [sumWidth-1:0]  sumI;
    logic signed [sumWidth-1:0]  sumQ;
    logic                        phase;
    logic                        accept;

    assign cicReady = !outValid || outReady;
    assign accept   = cicValid && cicReady;

    always_comb begin
        winI[0] = cicI; // Newest sample joins the window directly
        winQ[0] = cicQ;
        for (int k = 1; k < hbTaps; k++) begin
            winI[k] = dlyI[k-1];
            winQ[k] = dlyQ[k-1];
        end
        sumI = '0;
        sumQ = '0;
        for (int k = 0; k < hbTaps; k++) begin
            if (hbCoef[k] != 0) begin
                sumI = sumI + sumWidth'(winI[k]) * sumWidth'(hbCoef[k]);
                sumQ = sumQ + sumWidth'(winQ[k]) * sumWidth'(hbCoef[k]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || bypass) begin
            phase <= 1'b0;
            for (int k = 0; k < hbTaps - 1; k++) begin
                dlyI[k] <= '0;
                dlyQ[k] <= '0;
            end
        end else if (accept) begin
            phase   <= !phase;
            dlyI[0] <= cicI;
            dlyQ[0] <= cicQ;
            for (int k = 1; k < hbTaps - 1; k++) begin
                dlyI[k] <= dlyI[k-1];
                dlyQ[k] <= dlyQ[k-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (accept && (bypass || phase)) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && bypass) begin
            outI <= cicI;
            outQ <= cicQ;
        end else if (accept && phase) begin
            outI <= dataWidth'(sumI >>> hbShift); // Every second sample
            outQ <= dataWidth'(sumQ >>> hbShift);
        end
    end

endmodule

// ==== hdl/ddcTop.sv ====
module ddcTop #(
    parameter int dataWidth = 16,
    parameter int cicRate   = 4,
    parameter int cicStages = 3
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [11:0]                 addr,
    input  logic [31:0]                 wrData,
    input  logic [3:0]                  byteEn,
    input  logic                        wr,
    output logic [31:0]                 rdData,
    input  logic                        inValid,
    output logic                        inReady,
    input  logic signed [dataWidth-1:0] inData,
    output logic                        outValid,
    input  logic                        outReady,
    output logic signed [dataWidth-1:0] outI,
    output logic signed [dataWidth-1:0] outQ
);

    logic [31:0]                 centerFreq;
    logic                        bypassCic;
    logic                        bypassHb;
    logic                        mixValid;
    logic                        mixReady;
    logic signed [dataWidth-1:0] mixI;
    logic signed [dataWidth-1:0] mixQ;
    logic                        cicValid;
    logic                        cicReady;
    logic signed [dataWidth-1:0] cicI;
    logic signed [dataWidth-1:0] cicQ;

    ddcRegs ddcRegs_inst (.*);

    ddcNcoMixer #(
        .dataWidth(dataWidth)
    ) ddcNcoMixer_inst (.*);

    ddcCic #(
        .dataWidth(dataWidth),
        .cicRate  (cicRate),
        .cicStages(cicStages)
    ) ddcCic_inst (
        .bypass(bypassCic),
        .*
    );

    ddcHalfband #(
        .dataWidth(dataWidth)
    ) ddcHalfband_inst (
        .bypass(bypassHb),
        .*
    );

endmodule

// ==== verif/ddcTb.sv ====
module ddcTb import ddcPkg::*; ();

    localparam logic [1:0] patDc      = 2'd0;
    localparam logic [1:0] patQuarter = 2'd1;
    localparam logic [1:0] patDecim   = 2'd2;
    localparam int         decimTotal = 8; // CIC by 4, then halfband by 2

    typedef struct packed {
        logic [31:0]        freq;
        logic               bypassCic;
        logic               bypassHb;
        logic signed [15:0] dcValue;
        logic [15:0]        count;
        logic [1:0]         pattern;
        logic               pressure;
        logic [7:0]         settle;
    } stimRecord;

    logic               clk;
    logic               rst;
    logic [11:0]        addr;
    logic [31:0]        wrData;
    logic [3:0]         byteEn;
    logic               wr;
    logic [31:0]        rdData;
    logic               inValid;
    logic               inReady;
    logic signed [15:0] inData;
    logic               outValid;
    logic               outReady;
    logic signed [15:0] outI;
    logic signed [15:0] outQ;

    stimRecord          stimTable [6];
    logic signed [15:0] gotI [$];
    logic signed [15:0] gotQ [$];
    logic               collecting;
    logic               pressure;
    logic               holding;
    logic signed [15:0] heldI;
    logic signed [15:0] heldQ;
    logic [31:0]        rngState;

    ddcTop ddcTop_inst (.*);

    always #10 clk = !clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Quarter-rate mixing turns DC into a four-step rotation
    function automatic longint expectedI(input logic [1:0] pattern, input longint x, input int k);
        if (pattern == patQuarter) begin
            case (k % 4)
                0: return x;
                2: return -x;
                default: return 0;
            endcase
        end
        return x;
    endfunction

    function automatic longint expectedQ(input logic [1:0] pattern, input longint x, input int k);
        if (pattern == patQuarter) begin
            case (k % 4)
                1: return -x;
                3: return x;
                default: return 0;
            endcase
        end
        return 0;
    endfunction

    task automatic compareValue(input string name, input longint actual, input longint expected);
        if (actual != expected) begin
            $display("FAIL time %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            $display("test failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("test failed");
        $fatal(1, "Stopped after a timeout");
    endtask

    task automatic stepToDrive();
        @(posedge clk);
        #2;
    endtask

    task automatic applyReset();
        rst = 1'b1;
        repeat (16) stepToDrive();
        rst = 1'b0;
        @(negedge clk);
        compareValue("outValid", outValid, 0);
        compareValue("inReady", inReady, 1);
        stepToDrive();
    endtask

    task automatic writeReg(input logic [11:0] a, input logic [31:0] d, input logic [3:0] be);
        addr   = a;
        wrData = d;
        byteEn = be;
        wr     = 1'b1;
        stepToDrive();
        wr     = 1'b0;
        byteEn = '0;
    endtask

    task automatic checkRead(input logic [11:0] a, input logic [31:0] expected, input string name);
        addr = a;
        @(negedge clk);
        compareValue(name, rdData, expected);
        stepToDrive();
    endtask

    task automatic testRegisters();
        logic [31:0] target;
        logic [31:0] model;
        logic [31:0] data;
        ddcRegWord   ctrlWord;
        target = 32'hA1B2C3D4;
        model  = '0;
        checkRead(ddcCenterFreqAddr, model, "rdData (freq after reset)");
        checkRead(ddcControlAddr, 32'h0, "rdData (control after reset)");
        for (int b = 0; b < 4; b++) begin
            data             = ~target; // Lanes that are not enabled carry junk
            data[8*b +: 8]   = target[8*b +: 8];
            model[8*b +: 8]  = target[8*b +: 8];
            writeReg(ddcCenterFreqAddr, data, 4'(1 << b));
            checkRead(ddcCenterFreqAddr, model, $sformatf("rdData (freq byte %0d)", b));
        end
        model[23:16] = 8'h5A;
        writeReg(ddcCenterFreqAddr, 32'h5A5A5A5A, 4'b0100);
        checkRead(ddcCenterFreqAddr, model, "rdData (freq partial)");
        ctrlWord                = '0;
        ctrlWord.ctrl.reserved  = '1;
        ctrlWord.ctrl.bypassCic = 1'b1;
        writeReg(ddcControlAddr, ctrlWord, 4'hF);
        checkRead(ddcControlAddr, 32'h1, "rdData (bypassCic)");
        ctrlWord.ctrl.bypassCic = 1'b0;
        ctrlWord.ctrl.bypassHb  = 1'b1;
        writeReg(ddcControlAddr, ctrlWord, 4'h1);
        checkRead(ddcControlAddr, 32'h2, "rdData (bypassHb)");
        writeReg(ddcControlAddr, 32'hFFFFFFFF, 4'hE); // Byte 0 disabled, nothing changes
        checkRead(ddcControlAddr, 32'h2, "rdData (control upper lanes)");
        checkRead(12'h008, 32'h0, "rdData (unmapped 0x008)");
        checkRead(12'hFFC, 32'h0, "rdData (unmapped 0xFFC)");
    endtask

    task automatic sendSamples(input int count, input logic signed [15:0] x);
        int   sent;
        int   waitCycles;
        logic fire;
        sent       = 0;
        waitCycles = 0;
        while (sent < count) begin
            inValid = 1'b1;
            inData  = x;
            @(negedge clk);
            fire = inReady;
            stepToDrive();
            if (fire) begin
                sent++;
                waitCycles = 0;
            end else begin
                waitCycles++;
                if (waitCycles > 200) reportTimeout("inReady");
            end
        end
        inValid = 1'b0;
    endtask

    task automatic runRecord(input stimRecord rec);
        ddcRegWord ctrlWord;
        int        expCount;
        int        waitCycles;
        applyReset();
        writeReg(ddcCenterFreqAddr, rec.freq, 4'hF);
        ctrlWord                = '0;
        ctrlWord.ctrl.bypassCic = rec.bypassCic;
        ctrlWord.ctrl.bypassHb  = rec.bypassHb;
        writeReg(ddcControlAddr, ctrlWord, 4'h1);
        expCount = (rec.pattern == patDecim) ? int'(rec.count) / decimTotal : int'(rec.count);
        gotI.delete();
        gotQ.delete();
        pressure   = rec.pressure;
        collecting = 1'b1;
        sendSamples(rec.count, rec.dcValue);
        waitCycles = 0;
        while (gotI.size() < expCount) begin
            stepToDrive();
            waitCycles++;
            if (waitCycles > 500) reportTimeout("the output samples");
        end
        repeat (40) stepToDrive(); // Time for any surplus output to show up
        collecting = 1'b0;
        pressure   = 1'b0;
        compareValue("output count", gotI.size(), expCount);
        for (int k = 0; k < expCount; k++) begin
            if (k >= rec.settle) begin
                compareValue($sformatf("outI[%0d]", k), gotI[k],
                             expectedI(rec.pattern, rec.dcValue, k));
            end
            compareValue($sformatf("outQ[%0d]", k), gotQ[k],
                         expectedQ(rec.pattern, rec.dcValue, k));
        end
    endtask

    // Random back-pressure on the output
    always @(posedge clk) begin
        #2;
        if (pressure) begin
            rngState = xorshift32(rngState);
            outReady = rngState[0];
        end else begin
            outReady = 1'b1;
        end
    end

    // Collect transfers and watch that a stalled output holds still
    always @(negedge clk) begin
        if (collecting && holding) begin
            compareValue("outValid (held)", outValid, 1);
            compareValue("outI (held)", outI, heldI);
            compareValue("outQ (held)", outQ, heldQ);
        end
        holding = 1'b0;
        if (collecting && outValid) begin
            if (outReady) begin
                gotI.push_back(outI);
                gotQ.push_back(outQ);
            end else begin
                holding = 1'b1;
                heldI   = outI;
                heldQ   = outQ;
            end
        end
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        addr       = '0;
        wrData     = '0;
        byteEn     = '0;
        wr         = 1'b0;
        inValid    = 1'b0;
        inData     = '0;
        outReady   = 1'b1;
        collecting = 1'b0;
        pressure   = 1'b0;
        holding    = 1'b0;
        heldI      = '0;
        heldQ      = '0;
        rngState   = 32'd96387;
        // Settle of 6 skips the CIC and halfband start-up outputs
        stimTable[0] = '{32'h0, 1'b1, 1'b1, 16'sd1000, 16'd20, patDc, 1'b0, 8'd0};
        stimTable[1] = '{32'h40000000, 1'b1, 1'b1, -16'sd700, 16'd16, patQuarter, 1'b0, 8'd0};
        stimTable[2] = '{32'h0, 1'b0, 1'b0, 16'sd1000, 16'd96, patDecim, 1'b0, 8'd6};
        stimTable[3] = '{32'h0, 1'b1, 1'b1, 16'sd1000, 16'd20, patDc, 1'b1, 8'd0};
        stimTable[4] = '{32'h0, 1'b0, 1'b0, 16'sd1000, 16'd96, patDecim, 1'b1, 8'd6};
        stimTable[5] = '{32'h40000000, 1'b1, 1'b1, -16'sd1234, 16'd24, patQuarter, 1'b1, 8'd0};
        applyReset();
        testRegisters();
        for (int i = 0; i < 6; i++) begin
            runRecord(stimTable[i]);
        end
        $display("test passed");
        $finish;
    end

endmodule

// ==== ddc.f ====
hdl/ddcPkg.sv
hdl/ddcRegs.sv
hdl/ddcNcoMixer.sv
hdl/ddcCic.sv
hdl/ddcHalfband.sv
hdl/ddcTop.sv
verif/ddcTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ddcTb
FILELIST  ?= ddc.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
